/* hdl/lpf_coef_bank.sv */
/*
 * Coefficient source for the filter.
 * Cutoff CC messages set a pending preset, which becomes active on the
 * next accepted sample. Returns the coefficient for the current tap.
 */

`timescale 1ns/1ns

module lpf_coef_bank #(
    parameter logic [3:0] MIDI_CHANNEL = 4'd0,
    parameter logic [6:0] CUTOFF_CC    = 7'd74
) (
    input  logic                  reset,
    input  logic                  clk,
    input  logic                  midi_rdy,
    input  lpf_pkg::midi_event_t  midi_event,
    input  logic                  accept,
    input  lpf_pkg::tap_sel_t     tap_sel,
    output lpf_pkg::coef_t        coef
);

    logic       cc_hit;
    logic [2:0] pending_idx;
    logic [2:0] active_idx;

    // Our channel, our controller, Control Change only
    assign cc_hit = midi_rdy
                 && midi_event.cmd == lpf_pkg::MIDI_CMD_CC
                 && midi_event.ch == MIDI_CHANNEL
                 && midi_event.data0 == CUTOFF_CC;

    // ------------------------------------------------------------------
    // Preset index
    // ------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pending_idx <= 3'd0;
            active_idx  <= 3'd0;
        end else begin
            // Top three bits of the value pick one of eight sets
            if (cc_hit) begin
                pending_idx <= midi_event.data1[6:4];
            end
            // Switch only between computations
            if (accept) begin
                active_idx <= pending_idx;
            end
        end
    end

    // Table lookup, same cycle as tap_sel
    always_comb begin
        if (tap_sel < lpf_pkg::NUM_TAPS) begin
            coef = lpf_pkg::LPF_PRESETS[active_idx][tap_sel];
        end else begin
            coef = '0;
        end
    end

endmodule

/* hdl/lpf_control.sv */
/*
 * Sequencer for the shared multiply-accumulate.
 * Accepts a sample in IDLE or DONE, issues the five taps one per clock,
 * waits out the MAC pipeline and pulses done for one cycle.
 */

`timescale 1ns/1ns

module lpf_control (
    input  logic                reset,
    input  logic                clk,
    input  logic                sample_in_rdy,
    output logic                accept,
    output lpf_pkg::tap_sel_t   tap_sel,
    output lpf_pkg::mac_ctrl_t  mac_ctrl,
    output logic                done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_DRAIN,
        ST_DONE
    } state_t;

    state_t             state;
    lpf_pkg::tap_sel_t  tap_cnt;
    logic               drain_cnt;

    // ------------------------------------------------------------------
    // Strobes
    // ------------------------------------------------------------------
    // DONE counts as idle, so back-to-back samples 8 cycles apart pass
    assign accept = sample_in_rdy && (state == ST_IDLE || state == ST_DONE);

    // Result is valid in the accumulator for the whole DONE cycle
    assign done = (state == ST_DONE);

    // ------------------------------------------------------------------
    // State machine and tap issue
    // ------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state     <= ST_IDLE;
            tap_cnt   <= '0;
            drain_cnt <= 1'b0;
            tap_sel   <= '0;
            mac_ctrl  <= '0;
        end else begin
            // Registered issue, one cycle behind the counter
            tap_sel        <= tap_cnt;
            mac_ctrl.valid <= (state == ST_CALC);
            mac_ctrl.first <= (state == ST_CALC) && (tap_cnt == '0);

            case (state)
                ST_IDLE, ST_DONE: begin
                    if (accept) begin
                        state   <= ST_CALC;
                        tap_cnt <= '0;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_CALC: begin
                    if (tap_cnt == lpf_pkg::tap_sel_t'(lpf_pkg::NUM_TAPS - 1)) begin
                        state     <= ST_DRAIN;
                        drain_cnt <= 1'b0;
                    end else begin
                        tap_cnt <= tap_cnt + 3'd1;
                    end
                end
                ST_DRAIN: begin
                    // Two cycles: product register, then accumulator
                    if (drain_cnt) begin
                        state <= ST_DONE;
                    end else begin
                        drain_cnt <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/lpf_delay_line.sv */
/*
 * Sample history for the direct-form-I biquad.
 * x history shifts on accept, y history shifts on done, and the word
 * for the current tap is muxed out combinationally.
 */

`timescale 1ns/1ns

module lpf_delay_line (
    input  logic               reset,
    input  logic               clk,
    input  logic               accept,
    input  lpf_pkg::sample_t   sample_in,
    input  logic               done,
    input  lpf_pkg::sample_t   result,
    input  lpf_pkg::tap_sel_t  tap_sel,
    output lpf_pkg::sample_t   operand
);

    lpf_pkg::sample_t x0, x1, x2;
    lpf_pkg::sample_t y1, y2;

    // ------------------------------------------------------------------
    // History registers
    // ------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            x0 <= '0;
            x1 <= '0;
            x2 <= '0;
            y1 <= '0;
            y2 <= '0;
        end else begin
            // New input enters at x0
            if (accept) begin
                x0 <= sample_in;
                x1 <= x0;
                x2 <= x1;
            end
            // Finished output enters at y1
            if (done) begin
                y1 <= result;
                y2 <= y1;
            end
        end
    end

    // Operand select
    always_comb begin
        case (tap_sel)
            3'd0:    operand = x0;
            3'd1:    operand = x1;
            3'd2:    operand = x2;
            3'd3:    operand = y1;
            3'd4:    operand = y2;
            default: operand = '0;
        endcase
    end

endmodule

/* hdl/lpf_mac.sv */
/*
 * Shared multiply-accumulate with two pipeline stages.
 * Stage one registers the product, stage two loads or adds it into
 * the accumulator. The result is the saturated Q16-scaled sum.
 */

`timescale 1ns/1ns

module lpf_mac (
    input  logic                reset,
    input  logic                clk,
    input  lpf_pkg::mac_ctrl_t  mac_ctrl,
    input  lpf_pkg::sample_t    operand,
    input  lpf_pkg::coef_t      coef,
    output lpf_pkg::sample_t    result
);

    localparam int PROD_W = lpf_pkg::SAMPLE_W + lpf_pkg::COEF_W;

    logic signed [PROD_W-1:0]        prod_q;
    lpf_pkg::mac_ctrl_t              ctrl_q;
    logic signed [lpf_pkg::ACC_W-1:0] prod_ext;
    logic signed [lpf_pkg::ACC_W-1:0] acc;

    // ------------------------------------------------------------------
    // Stage one multiplies
    // ------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= mac_ctrl;
        end
    end

    // Signed product of operand and coefficient
    always_ff @(posedge reset) begin
        prod_q <= operand * coef;
    end

    // Sign-extend to accumulator width
    assign prod_ext = {{(lpf_pkg::ACC_W - PROD_W){prod_q[PROD_W-1]}}, prod_q};

    // ------------------------------------------------------------------
    // Stage two accumulates
    // ------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            acc <= '0;
        end else if (ctrl_q.valid) begin
            // First tap restarts the sum
            if (ctrl_q.first) begin
                acc <= prod_ext;
            end else begin
                acc <= acc + prod_ext;
            end
        end
    end

    // Drop fraction bits and clamp to sample range
    assign result = lpf_pkg::sat_sample(acc);

endmodule

/* hdl/lpf_pkg.sv */
/*
 * Shared definitions for the MIDI-controlled biquad low-pass filter.
 * Widths, bus structs, the preset coefficient table and the output
 * saturation function. Used by the RTL and by the reference model.
 */

package lpf_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int SAMPLE_W  = 18;
    localparam int COEF_W    = 18;  // Q2.16
    localparam int ACC_W     = 48;
    localparam int FRAC_BITS = 16;
    localparam int NUM_TAPS  = 5;

    // Control Change, status nibble 0xB without the top bit
    localparam logic [2:0] MIDI_CMD_CC = 3'b011;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEF_W-1:0]   coef_t;

    // 0..2 pick x0..x2, 3..4 pick y1..y2
    typedef logic [2:0] tap_sel_t;

    // Decoded MIDI message
    typedef struct packed {
        logic [2:0] cmd;
        logic [3:0] ch;
        logic [6:0] data0;  // Controller number
        logic [6:0] data1;  // Controller value
    } midi_event_t;

    // MAC issue controls
    typedef struct packed {
        logic valid;  // Product issued this cycle
        logic first;  // Product opens a new sum
    } mac_ctrl_t;

    // ------------------------------------------------------------------
    // Preset table
    // ------------------------------------------------------------------
    // Butterworth sections, Q = 0.707, low to high cutoff
    // Cutoff as fraction of fs: .01 .02 .04 .06 .10 .15 .20 .30
    // Tap order b0, b1, b2, -a1, -a2
    // Feedback taps stored negated so the MAC only adds
    localparam coef_t LPF_PRESETS [8][NUM_TAPS] = '{
        '{18'sd62,    18'sd124,   18'sd62,    18'sd125252, -18'sd59964},
        '{18'sd237,   18'sd474,   18'sd237,   18'sd119452, -18'sd54866},
        '{18'sd876,   18'sd1752,  18'sd876,   18'sd107968, -18'sd45934},
        '{18'sd1826,  18'sd3652,  18'sd1826,  18'sd96693,  -18'sd38461},
        '{18'sd4421,  18'sd8842,  18'sd4421,  18'sd74906,  -18'sd27053},
        '{18'sd8592,  18'sd17184, 18'sd8592,  18'sd49007,  -18'sd17840},
        '{18'sd13538, 18'sd27076, 18'sd13538, 18'sd24217,  -18'sd12833},
        '{18'sd25647, 18'sd51294, 18'sd25647, -18'sd24217, -18'sd12833}
    };

    // ------------------------------------------------------------------
    // Saturation
    // ------------------------------------------------------------------
    // Drop the Q16 fraction, then clamp to the sample range
    function automatic sample_t sat_sample(input logic signed [ACC_W-1:0] acc);
        logic signed [ACC_W-1:0] shifted;
        logic [ACC_W-SAMPLE_W:0] top;
        shifted = acc >>> FRAC_BITS;
        // Bits above the sample MSB must all copy the sign
        top = shifted[ACC_W-1:SAMPLE_W-1];
        if (top == '0 || top == '1) begin
            sat_sample = shifted[SAMPLE_W-1:0];
        end else if (shifted[ACC_W-1]) begin
            sat_sample = {1'b1, {(SAMPLE_W-1){1'b0}}};
        end else begin
            sat_sample = {1'b0, {(SAMPLE_W-1){1'b1}}};
        end
    endfunction

endpackage

/* hdl/lpf_top.sv */
/*
 * MIDI-controlled biquad low-pass filter for one synth voice.
 * One sample in per strobe, one result out 8 cycles later.
 * Samples strobed while a computation runs are dropped.
 */

`timescale 1ns/1ns

module lpf_top #(
    parameter logic [3:0] MIDI_CHANNEL = 4'd0,
    parameter logic [6:0] CUTOFF_CC    = 7'd74
) (
    input  logic                  reset,
    input  logic                  clk,
    input  logic                  midi_rdy,
    input  lpf_pkg::midi_event_t  midi_event,
    input  logic                  sample_in_rdy,
    input  lpf_pkg::sample_t      sample_in,
    output logic                  sample_out_rdy,
    output lpf_pkg::sample_t      sample_out
);

    logic               accept;
    logic               done;
    lpf_pkg::tap_sel_t  tap_sel;
    lpf_pkg::mac_ctrl_t mac_ctrl;
    lpf_pkg::coef_t     coef;
    lpf_pkg::sample_t   operand;
    lpf_pkg::sample_t   result;
    lpf_pkg::sample_t   sample_out_q;

    // ------------------------------------------------------------------
    // Datapath blocks
    // ------------------------------------------------------------------
    lpf_control u_control (
        .reset         (reset),
        .clk           (clk),
        .sample_in_rdy (sample_in_rdy),
        .accept        (accept),
        .tap_sel       (tap_sel),
        .mac_ctrl      (mac_ctrl),
        .done          (done)
    );

    lpf_coef_bank #(
        .MIDI_CHANNEL (MIDI_CHANNEL),
        .CUTOFF_CC    (CUTOFF_CC)
    ) u_coef_bank (
        .reset      (reset),
        .clk        (clk),
        .midi_rdy   (midi_rdy),
        .midi_event (midi_event),
        .accept     (accept),
        .tap_sel    (tap_sel),
        .coef       (coef)
    );

    lpf_delay_line u_delay_line (
        .reset     (reset),
        .clk       (clk),
        .accept    (accept),
        .sample_in (sample_in),
        .done      (done),
        .result    (result),
        .tap_sel   (tap_sel),
        .operand   (operand)
    );

    lpf_mac u_mac (
        .reset    (reset),
        .clk      (clk),
        .mac_ctrl (mac_ctrl),
        .operand  (operand),
        .coef     (coef),
        .result   (result)
    );

    // ------------------------------------------------------------------
    // Output
    // ------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sample_out_q <= '0;
        end else if (done) begin
            sample_out_q <= result;
        end
    end

    // Fresh result shown with the strobe, then held
    assign sample_out_rdy = done;
    assign sample_out     = done ? result : sample_out_q;

endmodule

/* synth_lpf.f */
hdl/lpf_pkg.sv
hdl/lpf_control.sv
hdl/lpf_coef_bank.sv
hdl/lpf_delay_line.sv
hdl/lpf_mac.sv
hdl/lpf_top.sv
test/lpf_assertions.sv
test/tb_lpf.sv

/* test/lpf_assertions.sv */
/*
 * Concurrent checks on the filter strobes, bound into lpf_top.
 * Covers output strobe width, the fixed 8-cycle latency and
 * samples accepted while a computation runs.
 */

`timescale 1ns/1ns

module lpf_assertions (
    input logic reset,
    input logic clk,
    input logic accept,
    input logic sample_out_rdy
);

    localparam int LATENCY = 8;

    // ------------------------------------------------------------------
    // Strobe rules
    // ------------------------------------------------------------------
    // Output strobe is a single-cycle pulse
    a_rdy_pulse: assert property (@(posedge reset) disable iff (clk)
        sample_out_rdy |=> !sample_out_rdy)
        else $error("sample_out_rdy high for two cycles in a row");

    // Every accepted sample gives a result 8 cycles later
    a_latency: assert property (@(posedge reset) disable iff (clk)
        accept |-> ##LATENCY sample_out_rdy)
        else $error("no sample_out_rdy 8 cycles after accept");

    // And no result appears without one
    a_rdy_source: assert property (@(posedge reset) disable iff (clk)
        sample_out_rdy |-> $past(accept, LATENCY))
        else $error("sample_out_rdy without an accept 8 cycles before");

    // Busy for 7 cycles after accept
    a_no_accept_busy: assert property (@(posedge reset) disable iff (clk)
        accept |=> (!accept) [*LATENCY-1])
        else $error("accept while a computation is running");

endmodule

/* test/tb_lpf.sv */
/*
 * Testbench for the MIDI-controlled biquad low-pass filter.
 * Drives samples and MIDI events into lpf_top, predicts each output
 * with a reference model and compares on every output strobe.
 */

`timescale 1ns/1ns

module tb_lpf;

    localparam logic [3:0] MIDI_CH     = 4'd0;
    localparam logic [6:0] CUTOFF_NUM  = 7'd74;
    localparam int LATENCY      = 8;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 10;
    localparam int IMPULSE_LEN  = 24;
    localparam int RAND_COUNT   = 200;
    localparam int CC_CYCLES    = 300;
    localparam int DROP_COUNT   = 10;
    localparam int DRAIN_CYCLES = 20;
    // Worst-case length of all stimulus phases
    localparam int STIM_CYCLES = RESET_CYCLES + IDLE_CYCLES + IMPULSE_LEN * LATENCY
                               + RAND_COUNT * 12 + CC_CYCLES + DROP_COUNT * 14
                               + DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

    // DUT port names: reset is the clock, clk the async reset
    logic                  reset;
    logic                  clk;
    logic                  midi_rdy;
    lpf_pkg::midi_event_t  midi_event;
    logic                  sample_in_rdy;
    lpf_pkg::sample_t      sample_in;
    logic                  sample_out_rdy;
    lpf_pkg::sample_t      sample_out;

    // Model state
    lpf_pkg::sample_t ref_x [3];
    lpf_pkg::sample_t ref_y [2];
    lpf_pkg::sample_t exp_q [$];
    lpf_pkg::sample_t exp_val;
    logic [2:0]       model_pending;
    logic [2:0]       model_active;
    int               edge_no;
    int               busy_until;
    int               err_cnt;
    int               out_cnt;

    lpf_top #(
        .MIDI_CHANNEL (MIDI_CH),
        .CUTOFF_CC    (CUTOFF_NUM)
    ) u_dut (
        .reset          (reset),
        .clk            (clk),
        .midi_rdy       (midi_rdy),
        .midi_event     (midi_event),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out)
    );

    bind lpf_top lpf_assertions u_assertions (
        .reset          (reset),
        .clk            (clk),
        .accept         (accept),
        .sample_out_rdy (sample_out_rdy)
    );

    // 4 ns period
    always #2 reset = ~reset;

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    // One biquad step from y = b0 x0 + b1 x1 + b2 x2 - a1 y1 - a2 y2
    function automatic lpf_pkg::sample_t lpf_step(input lpf_pkg::sample_t x_new,
                                                  input logic [2:0] preset);
        logic signed [lpf_pkg::ACC_W-1:0] acc;
        logic signed [lpf_pkg::ACC_W-1:0] op_w;
        logic signed [lpf_pkg::ACC_W-1:0] coef_w;
        lpf_pkg::sample_t ops [lpf_pkg::NUM_TAPS];
        lpf_pkg::sample_t y_new;
        int t;
        ref_x[2] = ref_x[1];
        ref_x[1] = ref_x[0];
        ref_x[0] = x_new;
        ops[0] = ref_x[0];
        ops[1] = ref_x[1];
        ops[2] = ref_x[2];
        ops[3] = ref_y[0];
        ops[4] = ref_y[1];
        acc = '0;
        for (t = 0; t < lpf_pkg::NUM_TAPS; t++) begin
            op_w   = ops[t];
            coef_w = lpf_pkg::LPF_PRESETS[preset][t];
            acc    = acc + op_w * coef_w;
        end
        y_new = lpf_pkg::sat_sample(acc);
        ref_y[1] = ref_y[0];
        ref_y[0] = y_new;
        return y_new;
    endfunction

    // Mix of full-scale steps and random words
    function automatic lpf_pkg::sample_t rand_sample();
        int pick;
        pick = $urandom_range(7, 0);
        if (pick < 2) begin
            return 18'sh1FFFF;
        end else if (pick == 2) begin
            return 18'sh20000;
        end
        return lpf_pkg::sample_t'($urandom);
    endfunction

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------
    task automatic tick();
        @(posedge reset);
        edge_no = edge_no + 1;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    task automatic send_sample(input lpf_pkg::sample_t x);
        sample_in_rdy <= 1'b1;
        sample_in     <= x;
        // Strobe is seen at the next edge, dropped while busy
        if (edge_no + 1 >= busy_until) begin
            model_active = model_pending;
            exp_q.push_back(lpf_step(x, model_active));
            busy_until = edge_no + 1 + LATENCY;
        end
        tick();
        sample_in_rdy <= 1'b0;
    endtask

    task automatic send_midi(input logic [2:0] cmd, input logic [3:0] ch,
                             input logic [6:0] num, input logic [6:0] val);
        midi_rdy   <= 1'b1;
        midi_event <= '{cmd: cmd, ch: ch, data0: num, data1: val};
        // Only a cutoff CC on our channel moves the pending preset
        if (cmd == lpf_pkg::MIDI_CMD_CC && ch == MIDI_CH && num == CUTOFF_NUM) begin
            model_pending = val[6:4];
        end
        tick();
        midi_rdy <= 1'b0;
    endtask

    task automatic run_samples(input int count, input int gap_lo, input int gap_hi);
        int n;
        for (n = 0; n < count; n++) begin
            send_sample(rand_sample());
            idle($urandom_range(gap_hi, gap_lo) - 1);
        end
    endtask

    // Output must stay quiet before the first sample
    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge reset);
            if (sample_out_rdy) begin
                $display("sample_out_rdy went high before any sample was sent");
                err_cnt++;
            end
            if (sample_out !== '0) begin
                $display("error sample_out expected %h got %h", 18'h0, sample_out);
                err_cnt++;
            end
            tick();
        end
    endtask

    // ------------------------------------------------------------------
    // Comparison, mid-cycle where outputs are stable
    // ------------------------------------------------------------------
    always @(negedge reset) begin
        if (!clk && sample_out_rdy) begin
            if (exp_q.size() == 0) begin
                $display("Output strobe at %0t with no sample outstanding", $time);
                err_cnt++;
            end else begin
                exp_val = exp_q.pop_front();
                out_cnt++;
                if (sample_out !== exp_val) begin
                    $display("error sample_out expected %h got %h", exp_val, sample_out);
                    err_cnt++;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin : main
        int n;
        int wait_cnt;
        reset         = 1'b0;
        clk           = 1'b1;
        midi_rdy      = 1'b0;
        midi_event    = '0;
        sample_in_rdy = 1'b0;
        sample_in     = '0;
        ref_x         = '{default: '0};
        ref_y         = '{default: '0};
        model_pending = 3'd0;
        model_active  = 3'd0;
        edge_no       = 0;
        busy_until    = 0;
        err_cnt       = 0;
        out_cnt       = 0;
        void'($urandom(32'h9019));

        idle(RESET_CYCLES);
        clk <= 1'b0;
        check_idle(IDLE_CYCLES);

        // Impulse then zeros, preset 0, back to back
        send_sample(18'sd100000);
        idle(LATENCY - 1);
        for (n = 1; n < IMPULSE_LEN; n++) begin
            send_sample('0);
            idle(LATENCY - 1);
        end

        // Random run, second half at the widest cutoff
        run_samples(RAND_COUNT / 2, 8, 12);
        send_midi(lpf_pkg::MIDI_CMD_CC, MIDI_CH, CUTOFF_NUM, 7'h7F);
        run_samples(RAND_COUNT / 2, 8, 12);

        // Preset select and ignored messages
        send_midi(lpf_pkg::MIDI_CMD_CC, MIDI_CH, CUTOFF_NUM, 7'h50);
        run_samples(8, 8, 10);
        send_midi(lpf_pkg::MIDI_CMD_CC, 4'd1, CUTOFF_NUM, 7'h10);
        send_midi(lpf_pkg::MIDI_CMD_CC, MIDI_CH, 7'd75, 7'h10);
        send_midi(3'b001, MIDI_CH, CUTOFF_NUM, 7'h10);
        run_samples(8, 8, 10);
        // CC in the middle of a computation
        send_sample(rand_sample());
        idle(2);
        send_midi(lpf_pkg::MIDI_CMD_CC, MIDI_CH, CUTOFF_NUM, 7'h25);
        idle(4);
        run_samples(8, 8, 10);

        // Second strobe lands 3 cycles into a computation
        for (n = 0; n < DROP_COUNT; n++) begin
            send_sample(rand_sample());
            idle(2);
            send_sample(rand_sample());
            idle(4 + $urandom_range(3, 0));
        end

        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_CYCLES) begin
            tick();
            wait_cnt++;
        end
        tick();
        if (exp_q.size() != 0) begin
            $display("%0d expected outputs never arrived", exp_q.size());
            err_cnt++;
        end
        if (out_cnt == 0) begin
            $display("No outputs were checked");
            err_cnt++;
        end

        $display("Checked %0d outputs, %0d errors", out_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin : watchdog
        int cyc;
        cyc = 0;
        while (cyc < TIMEOUT_CYCLES) begin
            @(posedge reset);
            cyc++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cyc);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
